//--- all.f
cdc_pkg.sv
msg_pkg.sv
cdc_fifo.sv
reg_bank.sv
cmd_ctrl.sv
cdc_bridge_top.sv
tb_cdc_bridge.sv

//--- cdc_bridge_top.sv
`timescale 1ns/1ps

module cdc_bridge_top (
    input  logic          wclk,
    input  logic          rclk,
    input  logic          rrst,

    // requester, wclk domain
    input  logic          cmd_push_i,
    input  msg_pkg::cmd_t cmd_i,
    output logic          cmd_full_o,
    output msg_pkg::rsp_t rsp_o,
    output logic          rsp_empty_o,
    input  logic          rsp_pop_i
);
    import msg_pkg::*;

    // rclk side of the command FIFO
    cmd_t cmd_rd;
    logic cmd_empty;
    logic cmd_pop;

    // rclk side of the response FIFO
    rsp_t rsp_wr;
    logic rsp_full;
    logic rsp_push;

    // register bank port
    logic [REG_AW-1:0] rd_addr;
    logic [REG_DW-1:0] rd_data;
    logic              wr_en;
    logic [REG_AW-1:0] wr_addr;
    logic              add;
    logic [REG_DW-1:0] wr_data;
    logic [REG_DW-1:0] new_data;

    // one reset serves both domains
    cdc_fifo #(
        .payload_t (cmd_t)
    ) i_cmd_fifo (
        .wclk_i  (wclk),
        .wrst_i  (rrst),
        .push_i  (cmd_push_i),
        .wdata_i (cmd_i),
        .full_o  (cmd_full_o),
        .rclk_i  (rclk),
        .rrst_i  (rrst),
        .pop_i   (cmd_pop),
        .rdata_o (cmd_rd),
        .empty_o (cmd_empty)
    );

    cdc_fifo #(
        .payload_t (rsp_t)
    ) i_rsp_fifo (
        .wclk_i  (rclk),  // written from the register side
        .wrst_i  (rrst),
        .push_i  (rsp_push),
        .wdata_i (rsp_wr),
        .full_o  (rsp_full),
        .rclk_i  (wclk),
        .rrst_i  (rrst),
        .pop_i   (rsp_pop_i),
        .rdata_o (rsp_o),
        .empty_o (rsp_empty_o)
    );

    cmd_ctrl i_cmd_ctrl (
        .rclk_i      (rclk),
        .rrst_i      (rrst),
        .cmd_i       (cmd_rd),
        .cmd_empty_i (cmd_empty),
        .cmd_pop_o   (cmd_pop),
        .rsp_o       (rsp_wr),
        .rsp_full_i  (rsp_full),
        .rsp_push_o  (rsp_push),
        .rd_addr_o   (rd_addr),
        .wr_en_o     (wr_en),
        .wr_addr_o   (wr_addr),
        .add_o       (add),
        .wr_data_o   (wr_data),
        .rd_data_i   (rd_data),
        .new_data_i  (new_data)
    );

    reg_bank i_reg_bank (
        .rclk_i     (rclk),
        .rrst_i     (rrst),
        .rd_addr_i  (rd_addr),
        .rd_data_o  (rd_data),
        .wr_en_i    (wr_en),
        .wr_addr_i  (wr_addr),
        .add_i      (add),
        .wr_data_i  (wr_data),
        .new_data_o (new_data)
    );

endmodule

//--- cdc_fifo.sv
`timescale 1ns/1ps

module cdc_fifo #(
    parameter type payload_t = logic [7:0]
) (
    // write side
    input  logic     wclk_i,
    input  logic     wrst_i,
    input  logic     push_i,
    input  payload_t wdata_i,
    output logic     full_o,

    // read side
    input  logic     rclk_i,
    input  logic     rrst_i,
    input  logic     pop_i,
    output payload_t rdata_o,
    output logic     empty_o
);
    import cdc_pkg::*;

    typedef logic [FIFO_PW-1:0] ptr_t;

    payload_t mem [FIFO_DEPTH];

    ptr_t wbin_q;
    ptr_t wbin_next;
    ptr_t wgray_q;
    ptr_t rbin_q;
    ptr_t rbin_next;
    ptr_t rgray_q;

    ptr_t wgray_sync_q [SYNC_STAGES];  // write pointer seen on rclk
    ptr_t rgray_sync_q [SYNC_STAGES];  // read pointer seen on wclk
    ptr_t wgray_rd;
    ptr_t rgray_wr;

    logic push_ok;
    logic pop_ok;

    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    assign push_ok = push_i && !full_o;   // push while full is dropped
    assign pop_ok  = pop_i && !empty_o;

    assign wbin_next = wbin_q + ptr_t'(push_ok);
    assign rbin_next = rbin_q + ptr_t'(pop_ok);

    // write pointer, gray copy registered so the crossing sees clean flops
    always_ff @(posedge wclk_i) begin
        if (wrst_i) begin
            wbin_q  <= '0;
            wgray_q <= '0;
        end else begin
            wbin_q  <= wbin_next;
            wgray_q <= bin2gray(wbin_next);
        end
    end

    always_ff @(posedge wclk_i) begin
        if (push_ok)
            mem[wbin_q[FIFO_AW-1:0]] <= wdata_i;
    end

    always_ff @(posedge rclk_i) begin
        if (rrst_i) begin
            rbin_q  <= '0;
            rgray_q <= '0;
        end else begin
            rbin_q  <= rbin_next;
            rgray_q <= bin2gray(rbin_next);
        end
    end

    assign rdata_o = mem[rbin_q[FIFO_AW-1:0]];  // show-ahead

    // write pointer into rclk domain
    always_ff @(posedge rclk_i) begin
        if (rrst_i) begin
            for (int i = 0; i < SYNC_STAGES; i++)
                wgray_sync_q[i] <= '0;
        end else begin
            wgray_sync_q[0] <= wgray_q;
            for (int i = 1; i < SYNC_STAGES; i++)
                wgray_sync_q[i] <= wgray_sync_q[i-1];
        end
    end

    // read pointer into wclk domain
    always_ff @(posedge wclk_i) begin
        if (wrst_i) begin
            for (int i = 0; i < SYNC_STAGES; i++)
                rgray_sync_q[i] <= '0;
        end else begin
            rgray_sync_q[0] <= rgray_q;
            for (int i = 1; i < SYNC_STAGES; i++)
                rgray_sync_q[i] <= rgray_sync_q[i-1];
        end
    end

    assign wgray_rd = wgray_sync_q[SYNC_STAGES-1];
    assign rgray_wr = rgray_sync_q[SYNC_STAGES-1];

    assign empty_o = (wgray_rd == rgray_q);

    // gray full test: the two top bits flipped, the rest equal
    assign full_o = (wgray_q == {~rgray_wr[FIFO_PW-1:FIFO_PW-2], rgray_wr[FIFO_PW-3:0]});

endmodule

//--- cdc_pkg.sv
package cdc_pkg;

    // geometry of the dual-clock FIFO

    localparam int unsigned FIFO_DEPTH = 4;

    // entry address width
    localparam int unsigned FIFO_AW = 2;

    // pointer width, one wrap bit above the address
    localparam int unsigned FIFO_PW = FIFO_AW + 1;

    // flops per pointer crossing
    localparam int unsigned SYNC_STAGES = 2;

endpackage

//--- cmd_ctrl.sv
`timescale 1ns/1ps

module cmd_ctrl (
    input  logic                       rclk_i,
    input  logic                       rrst_i,

    // command FIFO read side
    input  msg_pkg::cmd_t              cmd_i,
    input  logic                       cmd_empty_i,
    output logic                       cmd_pop_o,

    // response FIFO write side
    output msg_pkg::rsp_t              rsp_o,
    input  logic                       rsp_full_i,
    output logic                       rsp_push_o,

    // register bank
    output logic [msg_pkg::REG_AW-1:0] rd_addr_o,
    output logic                       wr_en_o,
    output logic [msg_pkg::REG_AW-1:0] wr_addr_o,
    output logic                       add_o,
    output logic [msg_pkg::REG_DW-1:0] wr_data_o,
    input  logic [msg_pkg::REG_DW-1:0] rd_data_i,
    input  logic [msg_pkg::REG_DW-1:0] new_data_i
);
    import msg_pkg::*;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_EXEC = 1'b1
    } state_e;

    state_e state_q;
    state_e state_d;

    cmd_t cmd_q;  // command in execution
    logic is_write;
    logic is_add;

    assign is_write = (cmd_q.op == OP_WRITE);
    assign is_add   = (cmd_q.op == OP_ADD);

    always_comb begin
        state_d    = state_q;
        cmd_pop_o  = 1'b0;
        rsp_push_o = 1'b0;
        wr_en_o    = 1'b0;
        add_o      = 1'b0;
        case (state_q)
            ST_IDLE: begin
                // only take a command when its response has room
                if (!cmd_empty_i && !rsp_full_i) begin
                    cmd_pop_o = 1'b1;
                    state_d   = ST_EXEC;
                end
            end
            ST_EXEC: begin
                wr_en_o    = is_write || is_add;
                add_o      = is_add;
                rsp_push_o = 1'b1;  // room checked in IDLE
                state_d    = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge rclk_i) begin
        if (rrst_i)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge rclk_i) begin
        if (cmd_pop_o)
            cmd_q <= cmd_i;
    end

    // read and write both hit the latched address
    assign rd_addr_o = cmd_q.addr;
    assign wr_addr_o = cmd_q.addr;
    assign wr_data_o = cmd_q.data;

    always_comb begin
        rsp_o.tag = cmd_q.tag;
        rsp_o.op  = cmd_q.op;
        case (cmd_q.op)
            OP_WRITE, OP_ADD: rsp_o.data = new_data_i;
            OP_READ:          rsp_o.data = rd_data_i;
            default:          rsp_o.data = '0;  // nop
        endcase
    end

endmodule

//--- msg_pkg.sv
package msg_pkg;

    // register bank geometry
    localparam int unsigned REG_COUNT = 16;
    localparam int unsigned REG_AW    = 4;
    localparam int unsigned REG_DW    = 16;

    localparam int unsigned TAG_W = 4;  // requester-chosen match tag

    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,
        OP_READ  = 2'd1,
        OP_ADD   = 2'd2,  // add immediate
        OP_NOP   = 2'd3
    } op_e;

    // requester -> register side
    typedef struct packed {
        op_e               op;
        logic [REG_AW-1:0] addr;
        logic [REG_DW-1:0] data;
        logic [TAG_W-1:0]  tag;
    } cmd_t;

    // register side -> requester
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        op_e               op;
        logic [REG_DW-1:0] data;  // register value after the op
    } rsp_t;

endpackage

//--- reg_bank.sv
`timescale 1ns/1ps

module reg_bank (
    input  logic                       rclk_i,
    input  logic                       rrst_i,

    // read port
    input  logic [msg_pkg::REG_AW-1:0] rd_addr_i,
    output logic [msg_pkg::REG_DW-1:0] rd_data_o,

    // update port
    input  logic                       wr_en_i,
    input  logic [msg_pkg::REG_AW-1:0] wr_addr_i,
    input  logic                       add_i,
    input  logic [msg_pkg::REG_DW-1:0] wr_data_i,
    output logic [msg_pkg::REG_DW-1:0] new_data_o
);
    import msg_pkg::*;

    logic [REG_DW-1:0] regs_q [REG_COUNT];

    assign rd_data_o = regs_q[rd_addr_i];

    // value the addressed register takes, add wraps at REG_DW bits
    always_comb begin
        if (add_i)
            new_data_o = rd_data_o + wr_data_i;
        else
            new_data_o = wr_data_i;
    end

    always_ff @(posedge rclk_i) begin
        if (rrst_i) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs_q[i] <= '0;
        end else if (wr_en_i) begin
            regs_q[wr_addr_i] <= new_data_o;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cdc_bridge -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_cdc_bridge)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
    exit 0
fi
echo "simulation reported failures"
exit 1

//--- tb_cdc_bridge.sv
`timescale 1ns/1ps

module tb_cdc_bridge;
    import msg_pkg::*;

    localparam int TIMEOUT = 2000;  // cycles per wait

    typedef struct packed {
        logic [3:0] test_id;
        cmd_t       cmd;
        rsp_t       want;
    } row_t;

    logic wclk = 1'b0;
    logic rclk = 1'b0;
    logic rrst;
    logic cmd_push_i;
    cmd_t cmd_i;
    logic cmd_full_o;
    rsp_t rsp_o;
    logic rsp_empty_o;
    logic rsp_pop_i;

    row_t              table_q [$];
    rsp_t              want_q [$];  // owed responses, command order
    logic [REG_DW-1:0] model_q [REG_COUNT];
    logic [3:0]        next_tag;
    int                errors;
    int                passed;
    int                failed;
    bit                pop_en;
    bit                rand_gaps;
    bit                timed_out;

    always #2 wclk = ~wclk;
    always #3 rclk = ~rclk;  // unrelated to wclk

    cdc_bridge_top i_cdc_bridge_top (
        .wclk        (wclk),
        .rclk        (rclk),
        .rrst        (rrst),
        .cmd_push_i  (cmd_push_i),
        .cmd_i       (cmd_i),
        .cmd_full_o  (cmd_full_o),
        .rsp_o       (rsp_o),
        .rsp_empty_o (rsp_empty_o),
        .rsp_pop_i   (rsp_pop_i)
    );

    task automatic report_value(input string sig, input logic [31:0] got,
                                input logic [31:0] want);
        $display("FAILED at %0d ns: %s is 'h%0h, expected 'h%0h", $time, sig, got, want);
        errors++;
    endtask

    task automatic note_timeout(input string what);
        $display("timeout: %s not seen within %0d cycles", what, TIMEOUT);
        errors++;
        timed_out = 1'b1;
    endtask

    // register bank rules applied in command order
    function automatic rsp_t predict(input cmd_t c);
        rsp_t r;
        r.tag = c.tag;
        r.op  = c.op;
        case (c.op)
            OP_WRITE: model_q[c.addr] = c.data;
            OP_ADD:   model_q[c.addr] = model_q[c.addr] + c.data;  // wraps at 16 bits
            default: ;
        endcase
        r.data = (c.op == OP_NOP) ? '0 : model_q[c.addr];
        return r;
    endfunction

    task automatic add_row(input int t, input op_e op, input int addr,
                           input logic [REG_DW-1:0] data);
        row_t r;
        r.test_id  = 4'(t);
        r.cmd.op   = op;
        r.cmd.addr = REG_AW'(addr);
        r.cmd.data = data;
        r.cmd.tag  = next_tag;
        r.want     = predict(r.cmd);
        next_tag++;
        table_q.push_back(r);
    endtask

    task automatic build_table();
        logic [1:0] op;
        for (int a = 0; a < REG_COUNT; a++)
            add_row(1, OP_READ, a, '0);
        add_row(2, OP_WRITE, 3, 16'h1234);
        add_row(2, OP_READ, 3, '0);
        add_row(2, OP_WRITE, 7, 16'hbeef);
        add_row(2, OP_READ, 7, '0);
        add_row(2, OP_WRITE, 3, 16'h5a5a);
        add_row(2, OP_READ, 3, '0);
        add_row(3, OP_WRITE, 5, 16'hfff0);
        add_row(3, OP_ADD, 5, 16'h0025);  // wraps past ffff
        add_row(3, OP_READ, 5, '0);
        add_row(3, OP_ADD, 5, 16'($urandom));
        add_row(3, OP_READ, 5, '0);
        add_row(3, OP_ADD, 12, 16'h0001);
        add_row(3, OP_READ, 12, '0);
        add_row(4, OP_NOP, 3, 16'haaaa);
        add_row(4, OP_READ, 3, '0);
        add_row(4, OP_NOP, 7, 16'hffff);
        add_row(4, OP_READ, 7, '0);
        for (int i = 0; i < 12; i++)
            add_row(5, (i % 3 == 0) ? OP_WRITE : (i % 3 == 1) ? OP_ADD : OP_READ,
                    8 + i % 4, 16'($urandom));
        for (int i = 0; i < 200; i++) begin
            op = 2'($urandom_range(3, 0));
            add_row(6, op_e'(op), int'($urandom_range(15, 0)), 16'($urandom));
        end
    endtask

    task automatic drive_push(input cmd_t c);
        @(posedge wclk);
        cmd_push_i <= 1'b1;
        cmd_i      <= c;
        @(posedge wclk);
        cmd_push_i <= 1'b0;
    endtask

    task automatic push_row(input row_t r);
        int n;
        n = 0;
        @(negedge wclk);
        while (cmd_full_o && !timed_out && n < TIMEOUT) begin
            @(negedge wclk);
            n++;
        end
        if (!timed_out) begin
            if (cmd_full_o) begin
                note_timeout("cmd_full_o falling");
            end else begin
                want_q.push_back(r.want);
                drive_push(r.cmd);
            end
        end
    endtask

    // FIFOs backed up, nothing popped yet
    task automatic hold_full();
        int n;
        cmd_t junk;
        n = 0;
        @(negedge wclk);
        while (!cmd_full_o && !timed_out && n < TIMEOUT) begin
            @(negedge wclk);
            n++;
        end
        if (!timed_out && !cmd_full_o) begin
            note_timeout("cmd_full_o rising");
        end else if (!timed_out) begin
            repeat (20) @(negedge wclk);
            if (!cmd_full_o) begin
                $display("cmd_full_o fell although no response was popped");
                errors++;
            end
            // dropped, or reg 0 and the response order go wrong
            junk = '{op: OP_WRITE, addr: '0, data: 16'hdead, tag: 4'hf};
            drive_push(junk);
        end
        pop_en = 1'b1;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (want_q.size() != 0 && !timed_out && n < TIMEOUT) begin
            @(negedge wclk);
            n++;
        end
        if (want_q.size() != 0 && !timed_out)
            note_timeout("the last response");
    endtask

    function automatic string test_name(input int t);
        case (t)
            1:       return "reset state";
            2:       return "write then read";
            3:       return "add immediate";
            4:       return "nop";
            5:       return "back-pressure";
            default: return "random sequence";
        endcase
    endfunction

    task automatic run_test(input int t);
        int err0;
        int cnt;
        err0      = errors;
        cnt       = 0;
        pop_en    = (t != 5);
        rand_gaps = (t == 6);
        if (t == 1) begin
            @(negedge wclk);
            if (cmd_full_o !== 1'b0)
                report_value("cmd_full_o", 32'(cmd_full_o), 32'd0);
            if (rsp_empty_o !== 1'b1)
                report_value("rsp_empty_o", 32'(rsp_empty_o), 32'd1);
        end
        foreach (table_q[i]) begin
            if (table_q[i].test_id == 4'(t) && !timed_out) begin
                if (t == 5 && cnt == 8)
                    hold_full();
                push_row(table_q[i]);
                cnt++;
            end
        end
        drain();
        if (t == 5 && !timed_out) begin
            repeat (30) @(negedge wclk);
            if (rsp_empty_o !== 1'b1) begin
                $display("an extra response came out after the backed-up commands");
                errors++;
            end
        end
        if (errors == err0)
            passed++;
        else
            failed++;
        $display("test %0d (%s): %0d commands, %s", t, test_name(t), cnt,
                 (errors == err0) ? "pass" : "FAIL");
    endtask

    // response side
    initial begin
        rsp_t got;
        rsp_t want;
        int   n;
        forever begin
            @(negedge wclk);
            if (pop_en && !timed_out && want_q.size() != 0) begin
                n = 0;
                while (rsp_empty_o && !timed_out && n < TIMEOUT) begin
                    @(negedge wclk);
                    n++;
                end
                if (rsp_empty_o) begin
                    if (!timed_out)
                        note_timeout("rsp_empty_o falling");
                end else begin
                    got  = rsp_o;
                    want = want_q.pop_front();
                    if (got.tag !== want.tag)
                        report_value("rsp_o.tag", 32'(got.tag), 32'(want.tag));
                    if (got.op !== want.op)
                        report_value("rsp_o.op", 32'(got.op), 32'(want.op));
                    if (got.data !== want.data)
                        report_value("rsp_o.data", 32'(got.data), 32'(want.data));
                    @(posedge wclk);
                    rsp_pop_i <= 1'b1;
                    @(posedge wclk);
                    rsp_pop_i <= 1'b0;
                    if (rand_gaps)
                        repeat ($urandom_range(3, 0)) @(posedge wclk);
                end
            end
        end
    end

    initial begin
        rrst       <= 1'b1;
        cmd_push_i <= 1'b0;
        cmd_i      <= '0;
        rsp_pop_i  <= 1'b0;
        pop_en    = 1'b0;
        rand_gaps = 1'b0;
        timed_out = 1'b0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        next_tag  = '0;
        for (int i = 0; i < REG_COUNT; i++)
            model_q[i] = '0;
        void'($urandom(32'h9153));
        build_table();
        repeat (10) @(posedge wclk);
        rrst <= 1'b0;
        for (int t = 1; t <= 6; t++)
            if (!timed_out)
                run_test(t);
        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
